/* design/motor_regs_pkg.sv */
// Register map, field positions and payload types of the motor register bus
// Imported by the decoder, the channel blocks and the top level
package motor_regs_pkg;

    // Bus and payload types
    typedef logic [5:0]  reg_addr_t;    // 6-bit register address
    typedef logic [7:0]  reg_byte_t;    // One register word
    typedef logic [11:0] angle_t;       // Target and current angle
    typedef logic [5:0]  adc_temp_t;    // Motor temperature from ADC
    typedef logic [4:0]  drive_pwm_t;   // Drive duty
    typedef logic [7:0]  pid_kp_t;      // Proportional constant, 4.4
    typedef logic [3:0]  pid_kik_t;     // Integral or derivative constant, 0.4
    typedef logic [5:0]  ovrd_ratio_t;  // Override duty

    // Channel counts, fixed by the map
    localparam int NUM_DRIVE = 4;
    localparam int NUM_ROT   = 4;
    localparam int ROT_REGS  = 7;       // Registers per rotation block

    // Broadcast writes hit every drive control register
    localparam reg_addr_t ADDR_BCAST_ALL   = 6'h01;
    localparam reg_addr_t ADDR_BCAST_DRIVE = 6'h03;

    // Drive channels: control at base + 2*n, status right after
    localparam reg_addr_t ADDR_DRIVE_BASE = 6'h04;
    localparam int        DRIVE_STRIDE    = 2;
    localparam int        DRIVE_CTRL      = 0;  // Byte index of control
    localparam int        DRIVE_STATUS    = 1;  // Byte index of status

    // Rotation blocks start here, ROT_REGS apart
    localparam reg_addr_t ADDR_ROT_BASE = 6'h0C;

    // Offsets inside a rotation block
    localparam int ROT_CTRL   = 0;
    localparam int ROT_TGT_LO = 1;
    localparam int ROT_CUR_LO = 2;
    localparam int ROT_CUR_HI = 3;      // Read: angle high, write: command
    localparam int ROT_KP     = 4;
    localparam int ROT_KIKD   = 5;
    localparam int ROT_OVRD   = 6;

    // Command bits written to ROT_CUR_HI
    localparam int CMD_ABORT_BIT  = 4;
    localparam int CMD_UPDATE_BIT = 5;
    localparam int CMD_SNAP_BIT   = 6;

    // Drive control fields, pwm in the low bits
    localparam int BRAKE_BIT  = 7;
    localparam int ENABLE_BIT = 6;
    localparam int DIR_BIT    = 5;

    // Rotation control fields
    localparam int ROT_ENABLE_BIT   = 6;
    localparam int STALL_BIT        = 5;
    localparam int STARTUP_FAIL_BIT = 4;  // Hardware status, not writable
    localparam int TGT_HI_MSB       = 3;
    localparam int TGT_HI_LSB       = 0;

    // PWM override fields, ratio in the low bits
    localparam int OVRD_EN_BIT  = 7;
    localparam int OVRD_DIR_BIT = 6;

endpackage

/* design/motor_reg_decoder.sv */
`timescale 1ns/10ps
// Address decode for the motor register bus
// Makes the per-channel write strobes and registers the selected read byte
module motor_reg_decoder (
    input  logic                                 clock,
    input  logic                                 rst_n,
    input  motor_regs_pkg::reg_addr_t            address,
    input  logic                                 write_en,
    input  logic                                 read_en,
    input  motor_regs_pkg::reg_byte_t
           [motor_regs_pkg::NUM_DRIVE-1:0][1:0]  drive_rd_bytes,  // Control, status
    input  motor_regs_pkg::reg_byte_t
           [motor_regs_pkg::NUM_ROT-1:0][motor_regs_pkg::ROT_REGS-1:0] rot_rd_bytes,
    output logic [motor_regs_pkg::NUM_DRIVE-1:0] drive_wr,        // Includes broadcasts
    output logic [motor_regs_pkg::NUM_ROT-1:0][motor_regs_pkg::ROT_REGS-1:0] rot_wr,
    output motor_regs_pkg::reg_byte_t            rd_data
);

    import motor_regs_pkg::*;

    logic      bcast;   // Either broadcast address
    reg_byte_t rd_sel;  // Byte at address, zero if unmapped

    assign bcast = (address == ADDR_BCAST_ALL) || (address == ADDR_BCAST_DRIVE);

    // Write strobes
    always_comb begin
        for (int d = 0; d < NUM_DRIVE; d++) begin
            drive_wr[d] = write_en &&
                          (bcast ||
                           (address == reg_addr_t'(ADDR_DRIVE_BASE + DRIVE_STRIDE * d)));
        end
        // One-hot per rotation block, one bit per register
        for (int r = 0; r < NUM_ROT; r++) begin
            for (int k = 0; k < ROT_REGS; k++) begin
                rot_wr[r][k] = write_en &&
                               (address == reg_addr_t'(ADDR_ROT_BASE + ROT_REGS * r + k));
            end
        end
    end

    // Read mux
    always_comb begin
        rd_sel = '0;  // Reserved and unmapped read zero
        for (int d = 0; d < NUM_DRIVE; d++) begin
            if (address == reg_addr_t'(ADDR_DRIVE_BASE + DRIVE_STRIDE * d + DRIVE_CTRL)) begin
                rd_sel = drive_rd_bytes[d][DRIVE_CTRL];
            end
            if (address == reg_addr_t'(ADDR_DRIVE_BASE + DRIVE_STRIDE * d + DRIVE_STATUS)) begin
                rd_sel = drive_rd_bytes[d][DRIVE_STATUS];
            end
        end
        for (int r = 0; r < NUM_ROT; r++) begin
            for (int k = 0; k < ROT_REGS; k++) begin
                if (address == reg_addr_t'(ADDR_ROT_BASE + ROT_REGS * r + k)) begin
                    rd_sel = rot_rd_bytes[r][k];
                end
            end
        end
    end

    // Read data holds between reads
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (read_en) begin
            rd_data <= rd_sel;  // Visible from the read edge on
        end
    end

endmodule

/* design/drive_channel.sv */
`timescale 1ns/10ps
// One drive motor channel: writable control byte and sampled status byte
// Instantiated once per drive motor by the top level
module drive_channel (
    input  logic                        clock,
    input  logic                        rst_n,
    input  logic                        wr,            // Own address or broadcast
    input  motor_regs_pkg::reg_byte_t   wr_data,
    input  logic                        fault,         // From motor driver
    input  logic                        startup_fail,
    input  motor_regs_pkg::adc_temp_t   adc_temp,
    output logic                        brake,
    output logic                        enable,
    output logic                        direction,
    output motor_regs_pkg::drive_pwm_t  pwm,
    output motor_regs_pkg::reg_byte_t   ctrl_byte,     // For read-back
    output motor_regs_pkg::reg_byte_t   status_byte
);

    import motor_regs_pkg::*;

    // Control register
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_byte <= '0;  // Motor off, brake released
        end else if (wr) begin
            ctrl_byte <= wr_data;
        end
    end

    // Control fields
    assign brake     = ctrl_byte[BRAKE_BIT];
    assign enable    = ctrl_byte[ENABLE_BIT];
    assign direction = ctrl_byte[DIR_BIT];
    assign pwm       = ctrl_byte[$bits(drive_pwm_t)-1:0];  // Duty in low bits

    // Status sampled every clock
    // Read-back lags the inputs by two edges
    always_ff @(posedge clock) begin
        status_byte <= {fault, startup_fail, adc_temp};
    end

endmodule

/* design/rotation_channel.sv */
`timescale 1ns/10ps
// One swerve rotation channel: seven-register block with PID constants,
// PWM override, angle snapshot and the update/abort command pulses
module rotation_channel (
    input  logic                                  clock,
    input  logic                                  rst_n,
    input  logic [motor_regs_pkg::ROT_REGS-1:0]   wr,            // One-hot per register
    input  motor_regs_pkg::reg_byte_t             wr_data,
    input  logic                                  startup_fail,  // Shared by all blocks
    input  motor_regs_pkg::angle_t                current_angle,
    input  logic                                  angle_done,
    output logic                                  enable,
    output logic                                  enable_stall_chk,
    output motor_regs_pkg::angle_t                target_angle,
    output motor_regs_pkg::pid_kp_t               kp,
    output motor_regs_pkg::pid_kik_t              ki,
    output motor_regs_pkg::pid_kik_t              kd,
    output logic                                  rot_pwm_ovrd,
    output logic                                  pwm_dir_ovrd,
    output motor_regs_pkg::ovrd_ratio_t           pwm_ratio_ovrd,
    output logic                                  update_angle,  // One-cycle pulse
    output logic                                  abort_angle,   // One-cycle pulse
    output motor_regs_pkg::reg_byte_t [motor_regs_pkg::ROT_REGS-1:0] reg_bytes
);

    import motor_regs_pkg::*;

    reg_byte_t ctrl_q;    // Enable, stall check, target high nibble
    reg_byte_t tgt_lo_q;  // Target angle low byte
    reg_byte_t kp_q;
    reg_byte_t kikd_q;    // Ki high nibble, kd low nibble
    reg_byte_t ovrd_q;
    angle_t    snap_q;    // Angle frozen by the snap command
    reg_byte_t cur_lo_q;
    reg_byte_t cur_hi_q;
    logic      cmd_wr;    // Write to the command address

    assign cmd_wr = wr[ROT_CUR_HI];

    // Writable registers
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q   <= '0;
            tgt_lo_q <= '0;
            kp_q     <= '0;
            kikd_q   <= '0;
            ovrd_q   <= '0;
        end else begin
            if (wr[ROT_CTRL]) begin
                // Bit 4 reports startup fail, the written bit is dropped
                ctrl_q <= {wr_data[7:STARTUP_FAIL_BIT+1], startup_fail,
                           wr_data[STARTUP_FAIL_BIT-1:0]};
            end
            if (wr[ROT_TGT_LO]) tgt_lo_q <= wr_data;
            if (wr[ROT_KP])     kp_q     <= wr_data;
            if (wr[ROT_KIKD])   kikd_q   <= wr_data;
            if (wr[ROT_OVRD])   ovrd_q   <= wr_data;
        end
    end

    // Command pulses and snapshot
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            update_angle <= 1'b0;
            abort_angle  <= 1'b0;
            snap_q       <= '0;
        end else begin
            update_angle <= cmd_wr && wr_data[CMD_UPDATE_BIT];  // Drops next cycle
            abort_angle  <= cmd_wr && wr_data[CMD_ABORT_BIT];
            // Both halves read later come from one capture, no tearing
            if (cmd_wr && wr_data[CMD_SNAP_BIT]) begin
                snap_q <= current_angle;
            end
        end
    end

    // Current angle read registers, refreshed every clock
    always_ff @(posedge clock) begin
        cur_lo_q <= snap_q[7:0];
        cur_hi_q <= {angle_done, 3'b000, snap_q[$bits(angle_t)-1:8]};
    end

    // Control and target fields
    assign enable           = ctrl_q[ROT_ENABLE_BIT];
    assign enable_stall_chk = ctrl_q[STALL_BIT];
    assign target_angle     = {ctrl_q[TGT_HI_MSB:TGT_HI_LSB], tgt_lo_q};

    // PID constants
    assign kp = kp_q;
    assign ki = kikd_q[7:$bits(pid_kik_t)];
    assign kd = kikd_q[$bits(pid_kik_t)-1:0];

    // Override fields
    assign rot_pwm_ovrd   = ovrd_q[OVRD_EN_BIT];
    assign pwm_dir_ovrd   = ovrd_q[OVRD_DIR_BIT];
    assign pwm_ratio_ovrd = ovrd_q[$bits(ovrd_ratio_t)-1:0];

    // Read-back bytes in block order
    assign reg_bytes[ROT_CTRL]   = ctrl_q;
    assign reg_bytes[ROT_TGT_LO] = tgt_lo_q;
    assign reg_bytes[ROT_CUR_LO] = cur_lo_q;
    assign reg_bytes[ROT_CUR_HI] = cur_hi_q;
    assign reg_bytes[ROT_KP]     = kp_q;
    assign reg_bytes[ROT_KIKD]   = kikd_q;
    assign reg_bytes[ROT_OVRD]   = ovrd_q;

endmodule

/* design/motor_regs.sv */
`timescale 1ns/10ps
// Top of the motor register file: bus decoder, four drive channels and
// four rotation channels, all on the byte-wide register bus
module motor_regs (
    input  logic                                       clock,
    input  logic                                       rst_n,
    // Register bus
    input  motor_regs_pkg::reg_addr_t                  address,
    input  logic                                       write_en,
    input  motor_regs_pkg::reg_byte_t                  wr_data,
    input  logic                                       read_en,
    output motor_regs_pkg::reg_byte_t                  rd_data,
    // Drive motors
    input  logic [motor_regs_pkg::NUM_DRIVE-1:0]       fault,
    input  motor_regs_pkg::adc_temp_t [motor_regs_pkg::NUM_DRIVE-1:0] adc_temp,
    input  logic [motor_regs_pkg::NUM_DRIVE:0]         startup_fail,  // Top bit for rotation
    output logic [motor_regs_pkg::NUM_DRIVE-1:0]       brake,
    output logic [motor_regs_pkg::NUM_DRIVE-1:0]       enable,
    output logic [motor_regs_pkg::NUM_DRIVE-1:0]       direction,
    output motor_regs_pkg::drive_pwm_t [motor_regs_pkg::NUM_DRIVE-1:0] pwm,
    // Rotation motors
    output logic [motor_regs_pkg::NUM_ROT-1:0]         rot_enable,
    output logic [motor_regs_pkg::NUM_ROT-1:0]         enable_stall_chk,
    output motor_regs_pkg::pid_kp_t [motor_regs_pkg::NUM_ROT-1:0]     kp,
    output motor_regs_pkg::pid_kik_t [motor_regs_pkg::NUM_ROT-1:0]    ki,
    output motor_regs_pkg::pid_kik_t [motor_regs_pkg::NUM_ROT-1:0]    kd,
    output logic [motor_regs_pkg::NUM_ROT-1:0]         rot_pwm_ovrd,
    output logic [motor_regs_pkg::NUM_ROT-1:0]         pwm_dir_ovrd,
    output motor_regs_pkg::ovrd_ratio_t [motor_regs_pkg::NUM_ROT-1:0] pwm_ratio_ovrd,
    output motor_regs_pkg::angle_t [motor_regs_pkg::NUM_ROT-1:0]      target_angle,
    input  motor_regs_pkg::angle_t [motor_regs_pkg::NUM_ROT-1:0]      current_angle,
    output logic [motor_regs_pkg::NUM_ROT-1:0]         update_angle,
    output logic [motor_regs_pkg::NUM_ROT-1:0]         abort_angle,
    input  logic [motor_regs_pkg::NUM_ROT-1:0]         angle_done
);

    import motor_regs_pkg::*;

    logic [NUM_DRIVE-1:0]                drive_wr;        // Drive control strobes
    logic [NUM_ROT-1:0][ROT_REGS-1:0]    rot_wr;          // Per-register strobes
    reg_byte_t [NUM_DRIVE-1:0][1:0]      drive_rd_bytes;  // Control and status
    reg_byte_t [NUM_ROT-1:0][ROT_REGS-1:0] rot_rd_bytes;

    motor_reg_decoder decoder_i (
        .clock          (clock),
        .rst_n          (rst_n),
        .address        (address),
        .write_en       (write_en),
        .read_en        (read_en),
        .drive_rd_bytes (drive_rd_bytes),
        .rot_rd_bytes   (rot_rd_bytes),
        .drive_wr       (drive_wr),
        .rot_wr         (rot_wr),
        .rd_data        (rd_data)
    );

    // Drive channels at 0x04..0x0B
    for (genvar d = 0; d < NUM_DRIVE; d++) begin : g_drive
        drive_channel drive_i (
            .clock        (clock),
            .rst_n        (rst_n),
            .wr           (drive_wr[d]),
            .wr_data      (wr_data),
            .fault        (fault[d]),
            .startup_fail (startup_fail[d]),
            .adc_temp     (adc_temp[d]),
            .brake        (brake[d]),
            .enable       (enable[d]),
            .direction    (direction[d]),
            .pwm          (pwm[d]),
            .ctrl_byte    (drive_rd_bytes[d][DRIVE_CTRL]),
            .status_byte  (drive_rd_bytes[d][DRIVE_STATUS])
        );
    end

    // Rotation blocks at 0x0C..0x27
    for (genvar r = 0; r < NUM_ROT; r++) begin : g_rot
        rotation_channel rot_i (
            .clock            (clock),
            .rst_n            (rst_n),
            .wr               (rot_wr[r]),
            .wr_data          (wr_data),
            .startup_fail     (startup_fail[NUM_DRIVE]),  // Shared rotation fail bit
            .current_angle    (current_angle[r]),
            .angle_done       (angle_done[r]),
            .enable           (rot_enable[r]),
            .enable_stall_chk (enable_stall_chk[r]),
            .target_angle     (target_angle[r]),
            .kp               (kp[r]),
            .ki               (ki[r]),
            .kd               (kd[r]),
            .rot_pwm_ovrd     (rot_pwm_ovrd[r]),
            .pwm_dir_ovrd     (pwm_dir_ovrd[r]),
            .pwm_ratio_ovrd   (pwm_ratio_ovrd[r]),
            .update_angle     (update_angle[r]),
            .abort_angle      (abort_angle[r]),
            .reg_bytes        (rot_rd_bytes[r])
        );
    end

endmodule

/* testbench/motor_regs_properties.sv */
`timescale 1ns/10ps
// Concurrent checks on the rotation command pulses and the read-data timing
// Bound into the decoder and each rotation channel from the testbench
module motor_regs_properties (
    input logic                      clock,
    input logic                      rst_n,
    input logic                      read_en,
    input motor_regs_pkg::reg_byte_t rd_data,
    input logic                      update_angle,
    input logic                      abort_angle
);

    // Command pulses are one cycle wide
    update_one_cycle: assert property (
        @(posedge clock) disable iff (!rst_n) update_angle |=> !update_angle
    ) else $error("update_angle stayed high for more than one cycle");

    abort_one_cycle: assert property (
        @(posedge clock) disable iff (!rst_n) abort_angle |=> !abort_angle
    ) else $error("abort_angle stayed high for more than one cycle");

    // Read data only moves on a read edge
    rd_data_held: assert property (
        @(posedge clock) disable iff (!rst_n) !read_en |=> $stable(rd_data)
    ) else $error("rd_data changed without read_en");

    // No pulse while reset is held
    pulses_quiet_in_reset: assert property (
        @(posedge clock) !rst_n |-> (!update_angle && !abort_angle)
    ) else $error("command pulse high during reset");

endmodule

/* testbench/motor_regs_tb.sv */
`timescale 1ns/10ps
// Directed testbench for the motor register file
// Drives the register bus and motor inputs, checks field outputs and read-back
module motor_regs_tb;

    import motor_regs_pkg::*;

    logic                          clock = 1'b0;
    logic                          rst_n;
    reg_addr_t                     address;
    logic                          write_en, read_en;
    reg_byte_t                     wr_data, rd_data;
    logic [NUM_DRIVE-1:0]          fault, brake, enable, direction;
    adc_temp_t [NUM_DRIVE-1:0]     adc_temp;
    logic [NUM_DRIVE:0]            startup_fail;      // Top bit shared by rotation
    drive_pwm_t [NUM_DRIVE-1:0]    pwm;
    logic [NUM_ROT-1:0]            rot_enable, enable_stall_chk, rot_pwm_ovrd, pwm_dir_ovrd;
    logic [NUM_ROT-1:0]            update_angle, abort_angle, angle_done;
    pid_kp_t [NUM_ROT-1:0]         kp;
    pid_kik_t [NUM_ROT-1:0]        ki, kd;
    ovrd_ratio_t [NUM_ROT-1:0]     pwm_ratio_ovrd;
    angle_t [NUM_ROT-1:0]          target_angle, current_angle;
    reg_byte_t rot_model [NUM_ROT][ROT_REGS] = '{default: '0};  // Expected rotation bytes
    int                            error_count = 0;

    motor_regs motor_regs_i (.*);

    bind motor_reg_decoder motor_regs_properties decoder_props_i (
        .clock(clock), .rst_n(rst_n), .read_en(read_en), .rd_data(rd_data),
        .update_angle(1'b0), .abort_angle(1'b0));
    bind rotation_channel motor_regs_properties rot_props_i (
        .clock(clock), .rst_n(rst_n), .read_en(1'b0), .rd_data(8'h00),
        .update_angle(update_angle), .abort_angle(abort_angle));

    always #50 clock = ~clock;  // 100 ns period

    task automatic check_byte(input string name, input reg_byte_t exp, input reg_byte_t act);
        if (act !== exp) begin
            error_count++;
            $display("ERROR %s: expected %02h, actual %02h", name, exp, act);
        end
    endtask

    task automatic check_angle(input string name, input angle_t exp, input angle_t act);
        if (act !== exp) begin
            error_count++;
            $display("ERROR %s: expected %03h, actual %03h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            error_count++;
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Every bus task starts and ends 10 ns after a rising edge
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clock);
            #10;
        end
    endtask

    task automatic bus_write(input reg_addr_t addr, input reg_byte_t data);
        address  = addr;
        wr_data  = data;
        write_en = 1'b1;
        idle_cycles(1);   // Write lands on this edge
        write_en = 1'b0;
    endtask

    task automatic bus_read(input reg_addr_t addr, output reg_byte_t data);
        address = addr;
        read_en = 1'b1;
        idle_cycles(1);
        read_en = 1'b0;
        data    = rd_data;
    endtask

    task automatic read_expect(input string name, input reg_addr_t addr, input reg_byte_t exp);
        reg_byte_t data;
        bus_read(addr, data);
        check_byte(name, exp, data);
    endtask

    // Counts high cycles of one pulse, bounded so a stuck pulse cannot hang
    task automatic check_pulse(input string name, input int r, input bit use_abort);
        int high_cycles;
        high_cycles = 0;
        while ((use_abort ? abort_angle[r] : update_angle[r]) && high_cycles < 8) begin
            high_cycles++;
            idle_cycles(1);
        end
        if (high_cycles != 1) begin
            error_count++;
            $display("ERROR %s: expected 1 cycle high, actual %0d cycles", name, high_cycles);
        end
    endtask

    task automatic check_drive_ctrls(input string name, input reg_byte_t exp);
        for (int d = 0; d < NUM_DRIVE; d++) begin
            check_byte(name, exp, {brake[d], enable[d], direction[d], pwm[d]});
            read_expect(name, reg_addr_t'(ADDR_DRIVE_BASE + 2 * d), exp);
        end
    endtask

    task automatic check_rot_model(input string name);
        for (int r = 0; r < NUM_ROT; r++) begin
            for (int k = 0; k < ROT_REGS; k++) begin
                if (k != ROT_CUR_LO && k != ROT_CUR_HI) begin  // Snapshot regs aside
                    read_expect(name, reg_addr_t'(ADDR_ROT_BASE + ROT_REGS * r + k),
                                rot_model[r][k]);
                end
            end
        end
    endtask

    task automatic test_reset();
        for (int d = 0; d < NUM_DRIVE; d++) begin
            check_byte("test_reset drive", 8'h00, {brake[d], enable[d], direction[d], pwm[d]});
        end
        for (int r = 0; r < NUM_ROT; r++) begin
            check_angle("test_reset target", '0, target_angle[r]);
            check_byte("test_reset kp", 8'h00, kp[r]);
            check_byte("test_reset kikd", 8'h00, {ki[r], kd[r]});
            check_byte("test_reset ovrd", 8'h00,
                       {rot_pwm_ovrd[r], pwm_dir_ovrd[r], pwm_ratio_ovrd[r]});
            check_bit("test_reset enables", 1'b0, rot_enable[r] | enable_stall_chk[r]);
            check_bit("test_reset pulses", 1'b0, update_angle[r] | abort_angle[r]);
        end
        check_byte("test_reset rd_data", 8'h00, rd_data);
    endtask

    task automatic test_drive_rw();
        reg_byte_t data;
        reg_addr_t ctrl_addr;
        for (int d = 0; d < NUM_DRIVE; d++) begin
            data      = reg_byte_t'($urandom);
            ctrl_addr = reg_addr_t'(ADDR_DRIVE_BASE + 2 * d);
            bus_write(ctrl_addr, data);
            check_bit("test_drive_rw brake", data[BRAKE_BIT], brake[d]);
            check_bit("test_drive_rw enable", data[ENABLE_BIT], enable[d]);
            check_bit("test_drive_rw direction", data[DIR_BIT], direction[d]);
            check_byte("test_drive_rw pwm", {3'b000, data[4:0]}, {3'b000, pwm[d]});
            read_expect("test_drive_rw ctrl", ctrl_addr, data);
            data            = reg_byte_t'($urandom);  // New status inputs
            fault[d]        = data[7];
            startup_fail[d] = data[6];
            adc_temp[d]     = data[5:0];
            idle_cycles(3);                            // Let the status sampler settle
            read_expect("test_drive_rw status", reg_addr_t'(ctrl_addr + 1), data);
        end
    endtask

    task automatic test_broadcast();
        reg_byte_t data;
        data = reg_byte_t'($urandom);
        bus_write(ADDR_BCAST_ALL, data);
        check_drive_ctrls("test_broadcast 0x01", data);
        data = reg_byte_t'($urandom);
        bus_write(ADDR_BCAST_DRIVE, data);
        check_drive_ctrls("test_broadcast 0x03", data);
        bus_write(6'h00, ~data);   // Reserved
        bus_write(6'h02, ~data);   // Unmapped
        check_drive_ctrls("test_broadcast reserved", data);
        check_rot_model("test_broadcast rotation");
    endtask

    task automatic test_rotation_regs();
        reg_byte_t data;
        reg_addr_t base;
        for (int r = 0; r < NUM_ROT; r++) begin
            base                    = reg_addr_t'(ADDR_ROT_BASE + ROT_REGS * r);
            startup_fail[NUM_DRIVE] = r[0];
            for (int k = 0; k < ROT_REGS; k++) begin
                if (k != ROT_CUR_LO && k != ROT_CUR_HI) begin
                    data = reg_byte_t'($urandom);
                    if (k == ROT_CTRL) begin
                        data[STARTUP_FAIL_BIT] = ~r[0];  // Written bit opposite the input
                    end
                    bus_write(reg_addr_t'(base + k), data);
                    rot_model[r][k] = data;
                end
            end
            rot_model[r][ROT_CTRL][STARTUP_FAIL_BIT] = r[0];  // Hardware bit wins
            check_bit("test_rotation_regs enable", rot_model[r][ROT_CTRL][ROT_ENABLE_BIT],
                      rot_enable[r]);
            check_bit("test_rotation_regs stall", rot_model[r][ROT_CTRL][STALL_BIT],
                      enable_stall_chk[r]);
            check_angle("test_rotation_regs target",
                        {rot_model[r][ROT_CTRL][TGT_HI_MSB:TGT_HI_LSB],
                         rot_model[r][ROT_TGT_LO]}, target_angle[r]);
            check_byte("test_rotation_regs kp", rot_model[r][ROT_KP], kp[r]);
            check_byte("test_rotation_regs kikd", rot_model[r][ROT_KIKD], {ki[r], kd[r]});
            check_byte("test_rotation_regs ovrd", rot_model[r][ROT_OVRD],
                       {rot_pwm_ovrd[r], pwm_dir_ovrd[r], pwm_ratio_ovrd[r]});
        end
        check_rot_model("test_rotation_regs readback");
    endtask

    task automatic test_angle_commands();
        angle_t    snap;
        reg_addr_t cmd_addr;
        reg_byte_t lo, hi;
        for (int r = 0; r < NUM_ROT; r++) begin
            cmd_addr = reg_addr_t'(ADDR_ROT_BASE + ROT_REGS * r + ROT_CUR_HI);
            bus_write(cmd_addr, 8'h01 << CMD_UPDATE_BIT);
            check_bit("test_angle_commands abort idle", 1'b0, abort_angle[r]);
            check_pulse("test_angle_commands update", r, 1'b0);
            bus_write(cmd_addr, 8'h01 << CMD_ABORT_BIT);
            check_bit("test_angle_commands update idle", 1'b0, update_angle[r]);
            check_pulse("test_angle_commands abort", r, 1'b1);
            snap             = angle_t'($urandom);
            current_angle[r] = snap;
            angle_done[r]    = 1'b1;
            bus_write(cmd_addr, 8'h01 << CMD_SNAP_BIT);
            current_angle[r] = ~snap;   // Angle moves on after the capture
            idle_cycles(1);             // Snapshot visible two cycles after the write
            bus_read(reg_addr_t'(cmd_addr - 1), lo);
            bus_read(cmd_addr, hi);
            check_angle("test_angle_commands snapshot", snap, {hi[3:0], lo});
            check_bit("test_angle_commands angle_done", 1'b1, hi[7]);
            check_byte("test_angle_commands hi pad", 8'h00, {1'b0, hi[6:4], 4'h0});
        end
    endtask

    initial begin
        void'($urandom(32'h4736));
        rst_n         = 1'b0;
        address       = '0;
        write_en      = 1'b0;
        read_en       = 1'b0;
        wr_data       = '0;
        fault         = '0;
        adc_temp      = '0;
        startup_fail  = '0;
        current_angle = '0;
        angle_done    = '0;
        repeat (2) @(posedge clock);  // Reset for two cycles
        #10;
        rst_n = 1'b1;
        test_reset();
        test_drive_rw();
        test_broadcast();
        test_rotation_regs();
        test_angle_commands();
        $display("Error count: %0d", error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* motor_regs.f */
design/motor_regs_pkg.sv
design/motor_reg_decoder.sv
design/drive_channel.sv
design/rotation_channel.sv
design/motor_regs.sv
testbench/motor_regs_properties.sv
testbench/motor_regs_tb.sv

/* Makefile */
# Verilator build and run of the motor register file testbench
VERILATOR ?= verilator
TOP       ?= motor_regs_tb
FILELIST  ?= motor_regs.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 --timescale 1ns/10ps
FAIL_MSG  ?= Done: errors found

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
